//--- design/cnn_pkg.sv
//------------------------------------------------
// frame sizes, sample types and padding opcode of
// the feature extractor, referenced by scoped name
//------------------------------------------------
package cnn_pkg;

    // frame geometry
    localparam int IMG_SIZE    = 5;
    localparam int KERNEL_SIZE = 2;
    localparam int PAD_SIZE    = IMG_SIZE + 2;
    localparam int MAP_SIZE    = PAD_SIZE - KERNEL_SIZE + 1;

    // pooling, window side equals stride
    localparam int POOL_WINDOW = 3;
    localparam int POOL_SIZE   = MAP_SIZE / POOL_WINDOW;

    localparam int OUT_CHANNELS        = 2;
    localparam int DEFAULT_IN_CHANNELS = 3;

    typedef logic signed [7:0] pixel_t;
    typedef logic signed [7:0] coef_t;

    // holds 12 full-scale 8x8 products with margin
    typedef logic signed [19:0] acc_t;

    typedef enum logic {
        PAD_ZERO      = 1'b0,
        PAD_REPLICATE = 1'b1
    } pad_mode_e;

endpackage

//--- design/frame_loader.sv
//------------------------------------------------
// input side: collects one frame from the stream
// and holds it until the pooled results are out
//------------------------------------------------
module frame_loader #(
    parameter int IN_CHANNELS = cnn_pkg::DEFAULT_IN_CHANNELS
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  cnn_pkg::pixel_t    pixel,
    input  cnn_pkg::coef_t     kernel_ch1,
    input  cnn_pkg::coef_t     kernel_ch2,
    input  cnn_pkg::pad_mode_e pad_mode,
    output logic               frame_valid,
    input  logic               frame_ready,
    input  logic               maps_done,
    output cnn_pkg::pixel_t    image [IN_CHANNELS*cnn_pkg::IMG_SIZE*cnn_pkg::IMG_SIZE],
    output cnn_pkg::coef_t     kernels [cnn_pkg::OUT_CHANNELS]
                                       [IN_CHANNELS*cnn_pkg::KERNEL_SIZE*cnn_pkg::KERNEL_SIZE],
    output cnn_pkg::pad_mode_e frame_pad
);

    localparam int FRAME_BEATS = IN_CHANNELS * cnn_pkg::IMG_SIZE * cnn_pkg::IMG_SIZE;
    localparam int KER_BEATS   = IN_CHANNELS * cnn_pkg::KERNEL_SIZE * cnn_pkg::KERNEL_SIZE;
    localparam int BEAT_W      = $clog2(FRAME_BEATS);
    localparam int KER_W       = $clog2(KER_BEATS);

    typedef enum logic [1:0] {
        LOAD,
        HANDOFF,
        WAIT_FREE
    } state_e;

    state_e            state;
    logic [BEAT_W-1:0] beat;
    logic              take;

    assign in_ready    = (state == LOAD);
    assign frame_valid = (state == HANDOFF);
    assign take        = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LOAD;
            beat  <= '0;
        end else begin
            case (state)
                LOAD: begin
                    if (take) begin
                        if (beat == BEAT_W'(FRAME_BEATS - 1)) begin
                            beat  <= '0;
                            state <= HANDOFF;
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end
                end
                HANDOFF: begin
                    if (frame_ready) begin
                        state <= WAIT_FREE;
                    end
                end
                // buffers stay busy until pooling has handed off
                WAIT_FREE: begin
                    if (maps_done) begin
                        state <= LOAD;
                    end
                end
                default: state <= LOAD;
            endcase
        end
    end

    // beat steering into the stores
    always_ff @(posedge clk) begin
        if (take) begin
            image[beat] <= pixel;
            if (beat < BEAT_W'(KER_BEATS)) begin
                kernels[0][beat[KER_W-1:0]] <= kernel_ch1;
                kernels[1][beat[KER_W-1:0]] <= kernel_ch2;
            end
            if (beat == '0) begin
                frame_pad <= pad_mode;
            end
        end
    end

endmodule

//--- design/conv_engine.sv
//------------------------------------------------
// padding and 2x2 convolution, one map position of
// one input channel per cycle for both output maps
//------------------------------------------------
module conv_engine #(
    parameter int IN_CHANNELS = cnn_pkg::DEFAULT_IN_CHANNELS
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               frame_valid,
    output logic               frame_ready,
    input  cnn_pkg::pixel_t    image [IN_CHANNELS*cnn_pkg::IMG_SIZE*cnn_pkg::IMG_SIZE],
    input  cnn_pkg::coef_t     kernels [cnn_pkg::OUT_CHANNELS]
                                       [IN_CHANNELS*cnn_pkg::KERNEL_SIZE*cnn_pkg::KERNEL_SIZE],
    input  cnn_pkg::pad_mode_e frame_pad,
    output logic               maps_valid,
    input  logic               maps_ready,
    output cnn_pkg::acc_t      maps [cnn_pkg::OUT_CHANNELS][cnn_pkg::MAP_SIZE*cnn_pkg::MAP_SIZE]
);

    localparam int KS       = cnn_pkg::KERNEL_SIZE;
    localparam int TAPS     = KS * KS;
    localparam int PAD_OFS  = (cnn_pkg::PAD_SIZE - cnn_pkg::IMG_SIZE) / 2;
    localparam int IMG_W    = $clog2(IN_CHANNELS * cnn_pkg::IMG_SIZE * cnn_pkg::IMG_SIZE);
    localparam int KER_W    = $clog2(IN_CHANNELS * TAPS);
    localparam int POS_W    = $clog2(cnn_pkg::MAP_SIZE);
    localparam int MAP_W    = $clog2(cnn_pkg::MAP_SIZE * cnn_pkg::MAP_SIZE);
    localparam int CH_W     = (IN_CHANNELS > 1) ? $clog2(IN_CHANNELS) : 1;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        HOLD
    } state_e;

    state_e             state;
    logic [CH_W-1:0]    ch;
    logic [POS_W-1:0]   row;
    logic [POS_W-1:0]   col;
    logic [MAP_W-1:0]   map_addr;
    cnn_pkg::pixel_t    tap [TAPS];
    cnn_pkg::acc_t      sum [cnn_pkg::OUT_CHANNELS];

    assign frame_ready = (state == IDLE) && frame_valid;
    assign maps_valid  = (state == HOLD);
    assign map_addr    = MAP_W'(int'(row) * cnn_pkg::MAP_SIZE + int'(col));

    // sample of the current channel at a padded coordinate
    function automatic cnn_pkg::pixel_t padded_tap(input int pr, input int pc);
        int   ir;
        int   ic;
        logic border;
        ir     = pr - PAD_OFS;
        ic     = pc - PAD_OFS;
        border = (ir < 0) || (ir >= cnn_pkg::IMG_SIZE) || (ic < 0) || (ic >= cnn_pkg::IMG_SIZE);
        if (ir < 0) ir = 0;
        if (ir >= cnn_pkg::IMG_SIZE) ir = cnn_pkg::IMG_SIZE - 1;
        if (ic < 0) ic = 0;
        if (ic >= cnn_pkg::IMG_SIZE) ic = cnn_pkg::IMG_SIZE - 1;
        if (border && frame_pad == cnn_pkg::PAD_ZERO) begin
            padded_tap = '0;
        end else begin
            padded_tap = image[IMG_W'(int'(ch) * cnn_pkg::IMG_SIZE * cnn_pkg::IMG_SIZE
                                      + ir * cnn_pkg::IMG_SIZE + ic)];
        end
    endfunction

    always_comb begin
        for (int dr = 0; dr < KS; dr++) begin
            for (int dc = 0; dc < KS; dc++) begin
                tap[dr*KS + dc] = padded_tap(int'(row) + dr, int'(col) + dc);
            end
        end
    end

    // four products per output map
    always_comb begin
        for (int oc = 0; oc < cnn_pkg::OUT_CHANNELS; oc++) begin
            sum[oc] = '0;
            for (int k = 0; k < TAPS; k++) begin
                sum[oc] = sum[oc] + cnn_pkg::acc_t'(tap[k])
                          * cnn_pkg::acc_t'(kernels[oc][KER_W'(int'(ch) * TAPS + k)]);
            end
        end
    end

    //------------------------------------------------
    // position walk
    //------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            ch    <= '0;
            row   <= '0;
            col   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (frame_valid) begin
                        state <= RUN;
                        ch    <= '0;
                        row   <= '0;
                        col   <= '0;
                    end
                end
                RUN: begin
                    if (col == POS_W'(cnn_pkg::MAP_SIZE - 1)) begin
                        col <= '0;
                        if (row == POS_W'(cnn_pkg::MAP_SIZE - 1)) begin
                            row <= '0;
                            if (ch == CH_W'(IN_CHANNELS - 1)) begin
                                state <= HOLD;
                            end else begin
                                ch <= ch + 1'b1;
                            end
                        end else begin
                            row <= row + 1'b1;
                        end
                    end else begin
                        col <= col + 1'b1;
                    end
                end
                HOLD: begin
                    if (maps_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // channel 0 starts a fresh sum
    always_ff @(posedge clk) begin
        if (state == RUN) begin
            for (int oc = 0; oc < cnn_pkg::OUT_CHANNELS; oc++) begin
                maps[oc][map_addr] <= ((ch == '0) ? cnn_pkg::acc_t'(0) : maps[oc][map_addr])
                                      + sum[oc];
            end
        end
    end

endmodule

//--- design/max_pool.sv
//------------------------------------------------
// 3x3 stride-3 max pooling of both feature maps,
// one map element per cycle
//------------------------------------------------
module max_pool (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          maps_valid,
    output logic          maps_ready,
    input  cnn_pkg::acc_t maps [cnn_pkg::OUT_CHANNELS][cnn_pkg::MAP_SIZE*cnn_pkg::MAP_SIZE],
    output logic          pool_valid,
    input  logic          pool_ready,
    output cnn_pkg::acc_t pooled [cnn_pkg::OUT_CHANNELS*cnn_pkg::POOL_SIZE*cnn_pkg::POOL_SIZE],
    output logic          maps_done
);

    localparam int PW    = cnn_pkg::POOL_WINDOW;
    localparam int PQ    = cnn_pkg::POOL_SIZE * cnn_pkg::POOL_SIZE;
    localparam int OFS_W = $clog2(PW);
    localparam int WIN_W = $clog2(cnn_pkg::POOL_SIZE);
    localparam int MAP_W = $clog2(cnn_pkg::MAP_SIZE * cnn_pkg::MAP_SIZE);
    localparam int OUT_W = $clog2(cnn_pkg::OUT_CHANNELS * PQ);

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        OFFER
    } state_e;

    state_e           state;
    // window index and offset inside the window
    logic [WIN_W-1:0] wr;
    logic [WIN_W-1:0] wc;
    logic [OFS_W-1:0] ir;
    logic [OFS_W-1:0] ic;
    logic [MAP_W-1:0] elem;
    logic [OUT_W-1:0] slot;
    logic             seed;

    assign maps_ready = (state == IDLE) && maps_valid;
    assign pool_valid = (state == OFFER);
    assign maps_done  = pool_valid && pool_ready;

    assign elem = MAP_W'((int'(wr) * PW + int'(ir)) * cnn_pkg::MAP_SIZE + int'(wc) * PW + int'(ic));
    assign slot = OUT_W'(int'(wr) * cnn_pkg::POOL_SIZE + int'(wc));
    assign seed = (ir == '0) && (ic == '0);

    // row-major scan of the map
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            wr    <= '0;
            wc    <= '0;
            ir    <= '0;
            ic    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (maps_valid) begin
                        state <= SCAN;
                        wr    <= '0;
                        wc    <= '0;
                        ir    <= '0;
                        ic    <= '0;
                    end
                end
                SCAN: begin
                    if (ic == OFS_W'(PW - 1)) begin
                        ic <= '0;
                        if (wc == WIN_W'(cnn_pkg::POOL_SIZE - 1)) begin
                            wc <= '0;
                            if (ir == OFS_W'(PW - 1)) begin
                                ir <= '0;
                                if (wr == WIN_W'(cnn_pkg::POOL_SIZE - 1)) begin
                                    state <= OFFER;
                                end else begin
                                    wr <= wr + 1'b1;
                                end
                            end else begin
                                ir <= ir + 1'b1;
                            end
                        end else begin
                            wc <= wc + 1'b1;
                        end
                    end else begin
                        ic <= ic + 1'b1;
                    end
                end
                OFFER: begin
                    if (pool_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SCAN) begin
            for (int oc = 0; oc < cnn_pkg::OUT_CHANNELS; oc++) begin
                if (seed || maps[oc][elem] > pooled[OUT_W'(oc * PQ) + slot]) begin
                    pooled[OUT_W'(oc * PQ) + slot] <= maps[oc][elem];
                end
            end
        end
    end

endmodule

//--- design/result_sender.sv
//------------------------------------------------
// output side: streams the eight pooled values
//------------------------------------------------
module result_sender (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          pool_valid,
    output logic          pool_ready,
    input  cnn_pkg::acc_t pooled [cnn_pkg::OUT_CHANNELS*cnn_pkg::POOL_SIZE*cnn_pkg::POOL_SIZE],
    output logic          out_valid,
    input  logic          out_ready,
    output cnn_pkg::acc_t result
);

    localparam int N_OUT = cnn_pkg::OUT_CHANNELS * cnn_pkg::POOL_SIZE * cnn_pkg::POOL_SIZE;
    localparam int IDX_W = $clog2(N_OUT);

    typedef enum logic {
        EMPTY,
        SEND
    } state_e;

    state_e           state;
    logic [IDX_W-1:0] idx;
    cnn_pkg::acc_t    held [N_OUT];

    // set is released back to pooling on its last beat
    assign pool_ready = (state == SEND) && out_ready && (idx == IDX_W'(N_OUT - 1));
    assign out_valid  = (state == SEND);
    assign result     = held[idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= EMPTY;
            idx   <= '0;
        end else begin
            case (state)
                EMPTY: begin
                    if (pool_valid) begin
                        state <= SEND;
                        idx   <= '0;
                    end
                end
                SEND: begin
                    // advance only on an accepted beat
                    if (out_ready) begin
                        if (idx == IDX_W'(N_OUT - 1)) begin
                            state <= EMPTY;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                default: state <= EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == EMPTY && pool_valid) begin
            held <= pooled;
        end
    end

endmodule

//--- design/cnn_top.sv
//------------------------------------------------
// feature extractor top: loader, convolution,
// pooling and output stage in a chain
//------------------------------------------------
module cnn_top #(
    parameter int IN_CHANNELS = cnn_pkg::DEFAULT_IN_CHANNELS
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  cnn_pkg::pixel_t    pixel,
    input  cnn_pkg::coef_t     kernel_ch1,
    input  cnn_pkg::coef_t     kernel_ch2,
    input  cnn_pkg::pad_mode_e pad_mode,
    output logic               out_valid,
    input  logic               out_ready,
    output cnn_pkg::acc_t      result
);

    logic               frame_valid;
    logic               frame_ready;
    logic               maps_valid;
    logic               maps_ready;
    logic               pool_valid;
    logic               pool_ready;
    logic               maps_done;
    cnn_pkg::pad_mode_e frame_pad;
    cnn_pkg::pixel_t    image [IN_CHANNELS*cnn_pkg::IMG_SIZE*cnn_pkg::IMG_SIZE];
    cnn_pkg::coef_t     kernels [cnn_pkg::OUT_CHANNELS]
                                [IN_CHANNELS*cnn_pkg::KERNEL_SIZE*cnn_pkg::KERNEL_SIZE];
    cnn_pkg::acc_t      maps [cnn_pkg::OUT_CHANNELS][cnn_pkg::MAP_SIZE*cnn_pkg::MAP_SIZE];
    cnn_pkg::acc_t      pooled [cnn_pkg::OUT_CHANNELS*cnn_pkg::POOL_SIZE*cnn_pkg::POOL_SIZE];

    frame_loader #(
        .IN_CHANNELS (IN_CHANNELS)
    ) frame_loader_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .pixel       (pixel),
        .kernel_ch1  (kernel_ch1),
        .kernel_ch2  (kernel_ch2),
        .pad_mode    (pad_mode),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready),
        .maps_done   (maps_done),
        .image       (image),
        .kernels     (kernels),
        .frame_pad   (frame_pad)
    );

    conv_engine #(
        .IN_CHANNELS (IN_CHANNELS)
    ) conv_engine_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready),
        .image       (image),
        .kernels     (kernels),
        .frame_pad   (frame_pad),
        .maps_valid  (maps_valid),
        .maps_ready  (maps_ready),
        .maps        (maps)
    );

    max_pool max_pool_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .maps_valid (maps_valid),
        .maps_ready (maps_ready),
        .maps       (maps),
        .pool_valid (pool_valid),
        .pool_ready (pool_ready),
        .pooled     (pooled),
        .maps_done  (maps_done)
    );

    result_sender result_sender_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .pool_valid (pool_valid),
        .pool_ready (pool_ready),
        .pooled     (pooled),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .result     (result)
    );

endmodule

//--- bench/cnn_model.svh
//------------------------------------------------
// reference model of padding, convolution and pooling,
// included inside the testbench module
//------------------------------------------------
`ifndef CNN_MODEL_SVH
`define CNN_MODEL_SVH

// padded coordinates sit one step off the image
function automatic int padded_sample(input int c, input int pr, input int pc);
    int r;
    int k;
    r = pr - 1;
    k = pc - 1;
    if (r < 0 || r >= cnn_pkg::IMG_SIZE || k < 0 || k >= cnn_pkg::IMG_SIZE) begin
        if (frame_mode == cnn_pkg::PAD_ZERO) begin
            return 0;
        end
        // replicate takes the nearest edge pixel
        if (r < 0) begin
            r = 0;
        end
        if (r >= cnn_pkg::IMG_SIZE) begin
            r = cnn_pkg::IMG_SIZE - 1;
        end
        if (k < 0) begin
            k = 0;
        end
        if (k >= cnn_pkg::IMG_SIZE) begin
            k = cnn_pkg::IMG_SIZE - 1;
        end
    end
    return int'(frame_img[c * cnn_pkg::IMG_SIZE * cnn_pkg::IMG_SIZE + r * cnn_pkg::IMG_SIZE + k]);
endfunction

// pushes the eight pooled values in output order
function automatic void compute_expected();
    int fmap [cnn_pkg::OUT_CHANNELS][cnn_pkg::MAP_SIZE*cnn_pkg::MAP_SIZE];
    int s;
    int best;
    int v;
    int ks;
    ks = cnn_pkg::KERNEL_SIZE;
    for (int oc = 0; oc < cnn_pkg::OUT_CHANNELS; oc++) begin
        for (int r = 0; r < cnn_pkg::MAP_SIZE; r++) begin
            for (int c = 0; c < cnn_pkg::MAP_SIZE; c++) begin
                s = 0;
                for (int ch = 0; ch < IN_CH; ch++) begin
                    for (int kr = 0; kr < ks; kr++) begin
                        for (int kc = 0; kc < ks; kc++) begin
                            s += padded_sample(ch, r + kr, c + kc)
                                 * int'(frame_ker[oc][ch * ks * ks + kr * ks + kc]);
                        end
                    end
                end
                fmap[oc][r * cnn_pkg::MAP_SIZE + c] = s;
            end
        end
    end
    // pooling windows, row-major per map
    for (int oc = 0; oc < cnn_pkg::OUT_CHANNELS; oc++) begin
        for (int wr = 0; wr < cnn_pkg::POOL_SIZE; wr++) begin
            for (int wc = 0; wc < cnn_pkg::POOL_SIZE; wc++) begin
                best = fmap[oc][wr * cnn_pkg::POOL_WINDOW * cnn_pkg::MAP_SIZE
                                + wc * cnn_pkg::POOL_WINDOW];
                for (int dr = 0; dr < cnn_pkg::POOL_WINDOW; dr++) begin
                    for (int dc = 0; dc < cnn_pkg::POOL_WINDOW; dc++) begin
                        v = fmap[oc][(wr * cnn_pkg::POOL_WINDOW + dr) * cnn_pkg::MAP_SIZE
                                     + wc * cnn_pkg::POOL_WINDOW + dc];
                        if (v > best) begin
                            best = v;
                        end
                    end
                end
                expected_q.push_back(cnn_pkg::acc_t'(best));
            end
        end
    end
endfunction

`endif

//--- bench/cnn_tb.sv
//------------------------------------------------
// testbench: random frames in, pooled results out,
// compared against the included model
//------------------------------------------------
module cnn_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IN_CH       = cnn_pkg::DEFAULT_IN_CHANNELS;
    localparam int FRAME_BEATS = IN_CH * cnn_pkg::IMG_SIZE * cnn_pkg::IMG_SIZE;
    localparam int KER_BEATS   = IN_CH * cnn_pkg::KERNEL_SIZE * cnn_pkg::KERNEL_SIZE;
    localparam int N_OUT       = cnn_pkg::OUT_CHANNELS * cnn_pkg::POOL_SIZE * cnn_pkg::POOL_SIZE;
    localparam int N_FRAMES    = 8;
    localparam int WAIT_LIMIT  = 2000;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               in_valid;
    logic               in_ready;
    cnn_pkg::pixel_t    pixel;
    cnn_pkg::coef_t     kernel_ch1;
    cnn_pkg::coef_t     kernel_ch2;
    cnn_pkg::pad_mode_e pad_mode;
    logic               out_valid;
    logic               out_ready;
    cnn_pkg::acc_t      result;

    logic [31:0]        rng_state = 32'd98695;
    cnn_pkg::pixel_t    frame_img [FRAME_BEATS];
    cnn_pkg::coef_t     frame_ker [cnn_pkg::OUT_CHANNELS][KER_BEATS];
    cnn_pkg::pad_mode_e frame_mode;
    cnn_pkg::acc_t      expected_q [$];
    int                 results_seen;

    `include "cnn_model.svh"

    cnn_top #(
        .IN_CHANNELS (IN_CH)
    ) cnn_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .pixel      (pixel),
        .kernel_ch1 (kernel_ch1),
        .kernel_ch2 (kernel_ch2),
        .pad_mode   (pad_mode),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .result     (result)
    );

    always #20 clk = ~clk;

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_result(input cnn_pkg::acc_t got, input cnn_pkg::acc_t expected,
                                input string what);
        if (got !== expected) begin
            stop_on_error($sformatf("mismatch at time %0t: %s, got %0d, expected %0d",
                                    $time, what, got, expected));
        end
    endtask

    task automatic check_flag(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            stop_on_error($sformatf("mismatch at time %0t: %s, got %b, expected %b",
                                    $time, what, got, expected));
        end
    endtask

    // last frame all -128 and the one before random full-scale values
    function automatic logic [7:0] pick_value(input int f);
        logic [31:0] r;
        r = next_rand();
        if (f == N_FRAMES - 1) begin
            return 8'h80;
        end
        if (f == N_FRAMES - 2) begin
            return r[0] ? 8'h7f : 8'h80;
        end
        return r[7:0];
    endfunction

    task automatic make_frame(input int f);
        frame_mode = (f % 2 == 1) ? cnn_pkg::PAD_REPLICATE : cnn_pkg::PAD_ZERO;
        for (int i = 0; i < FRAME_BEATS; i++) begin
            frame_img[i] = pick_value(f);
        end
        for (int oc = 0; oc < cnn_pkg::OUT_CHANNELS; oc++) begin
            for (int k = 0; k < KER_BEATS; k++) begin
                frame_ker[oc][k] = pick_value(f);
            end
        end
    endtask

    task automatic drive_frames();
        int          waited;
        logic [31:0] junk;
        for (int f = 0; f < N_FRAMES; f++) begin
            make_frame(f);
            compute_expected();
            for (int n = 0; n < FRAME_BEATS; n++) begin
                // beat 0 of a later frame follows the last beat with in_valid still high
                if ((f == 0 || n > 0) && next_rand() % 4 == 0) begin
                    in_valid = 1'b0;
                    @(negedge clk);
                end
                junk       = next_rand();
                in_valid   = 1'b1;
                pixel      = frame_img[n];
                kernel_ch1 = (n < KER_BEATS) ? frame_ker[0][n] : junk[7:0];
                kernel_ch2 = (n < KER_BEATS) ? frame_ker[1][n] : junk[15:8];
                pad_mode   = (n == 0) ? frame_mode : cnn_pkg::pad_mode_e'(junk[16]);
                waited     = 0;
                while (!in_ready) begin
                    @(negedge clk);
                    waited++;
                    if (waited > WAIT_LIMIT) begin
                        stop_on_error("input beat was never accepted by the DUT");
                    end
                end
                if (f > 0 && n == 0) begin
                    // previous frame fully drained before the next one loads
                    check_flag(out_valid, 1'b0, "in_ready before previous frame results");
                    check_flag(results_seen == f * N_OUT, 1'b1,
                               "beat accepted before previous frame results were taken");
                end
                @(negedge clk);
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_results();
        int            waited;
        int            free_wait;
        logic          stalled;
        cnn_pkg::acc_t held;
        cnn_pkg::acc_t expected;
        waited    = 0;
        free_wait = -1;
        stalled   = 1'b0;
        held      = '0;
        while (results_seen < N_FRAMES * N_OUT) begin
            @(negedge clk);
            // input side frees up within two cycles of a frame's last result
            if (free_wait >= 0) begin
                if (in_ready) begin
                    free_wait = -1;
                end else if (free_wait >= 2) begin
                    stop_on_error("in_ready did not return after the last result of a frame");
                end else begin
                    free_wait++;
                end
            end
            if (stalled) begin
                check_flag(out_valid, 1'b1, "out_valid dropped during a stall");
                check_result(result, held, "result changed during a stall");
            end
            out_ready = (next_rand() % 3 != 0);
            stalled   = out_valid && !out_ready;
            held      = result;
            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    stop_on_error("DUT produced a result with no frame outstanding");
                end
                expected = expected_q.pop_front();
                check_result(result, expected, $sformatf("result %0d", results_seen));
                results_seen++;
                waited = 0;
                if (results_seen % N_OUT == 0) begin
                    free_wait = 1;
                end
            end else begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    stop_on_error("no result arrived from the DUT in time");
                end
            end
        end
        @(negedge clk);
        out_ready = 1'b0;
    endtask

    initial begin
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        pixel        = '0;
        kernel_ch1   = '0;
        kernel_ch2   = '0;
        pad_mode     = cnn_pkg::PAD_ZERO;
        out_ready    = 1'b0;
        results_seen = 0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_flag(in_ready, 1'b1, "in_ready after reset");
        check_flag(out_valid, 1'b0, "out_valid after reset");
        fork
            drive_frames();
            collect_results();
        join
        if (results_seen == N_FRAMES * N_OUT && expected_q.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_on_error("run ended with results still outstanding");
        end
    end

endmodule

//--- sources.f
+incdir+bench
design/cnn_pkg.sv
design/frame_loader.sv
design/conv_engine.sv
design/max_pool.sv
design/result_sender.sv
design/cnn_top.sv
bench/cnn_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the feature extractor testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing -f sources.f --top-module cnn_tb -o cnn_sim
./obj_dir/cnn_sim | tee sim.log
if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
